// File: hw/cpu_pkg.sv
// --------------------
// CPU shared definitions
// Opcodes, instruction word views and flag positions
// --------------------

package cpu_pkg;

	// Register number
	typedef logic [0:2] cpu_reg_t;

	// --------------------
	// Opcodes
	// --------------------

	// Codes missing from this list decode as illegal
	typedef enum logic [0:5] {
		OP_LW  = 6'o10,
		OP_RW  = 6'o11,
		OP_AW  = 6'o20,
		OP_SW  = 6'o21,
		OP_OR  = 6'o22,
		OP_NR  = 6'o23,
		OP_ER  = 6'o24,
		OP_LWT = 6'o40,
		OP_AWT = 6'o41,
		OP_HLT = 6'o51
	} cpu_op_t;

	// --------------------
	// Instruction word
	// --------------------

	// Two-register form
	typedef struct packed {
		logic [0:5] op;
		logic       spare;
		cpu_reg_t   a;
		cpu_reg_t   b;
		logic [0:2] unused;
	} cpu_instr_rg_t;

	// Short-argument form with signed t
	typedef struct packed {
		logic [0:5] op;
		logic       ignored;
		cpu_reg_t   a;
		logic [0:5] t;
	} cpu_instr_sh_t;

	typedef union packed {
		cpu_instr_rg_t rg;
		cpu_instr_sh_t sh;
	} cpu_instr_t;

	// --------------------
	// Flag bits in R0
	// --------------------

	localparam int FLAG_Z = 0;
	localparam int FLAG_M = 1;
	localparam int FLAG_V = 2;
	localparam int FLAG_C = 3;

endpackage

// File: hw/px.sv
// --------------------
// PX bus sequencer
// Instruction FSM and system bus strobes
// Alarm timer on every bus cycle and halt logic
// --------------------

`timescale 1ns/1ps

module px #(
	parameter int ALARM_DLY_TICKS = 64
) (
	input  logic __clk,
	input  logic arst_n,
	input  logic start,
	input  logic stop,
	input  logic reg_op,
	input  logic mem_rd,
	input  logic mem_wr,
	input  logic halt,
	input  logic illegal,
	input  logic rok,
	input  logic ren,
	input  logic rpe,
	output logic dr,
	output logic dw,
	output logic run,
	output logic hlt_n,
	output logic awaria,
	output logic w_ir,
	output logic w_r,
	output logic w_ac,
	output logic icp1,
	output logic ic_ad,
	output logic ar_ad
);

	localparam logic [2:0] ST_STOP   = 3'd0;
	localparam logic [2:0] ST_FETCH  = 3'd1;
	localparam logic [2:0] ST_DECODE = 3'd2;
	localparam logic [2:0] ST_EXEC   = 3'd3;
	localparam logic [2:0] ST_MEM    = 3'd4;
	localparam logic [2:0] ST_HALT   = 3'd5;

	localparam int CNT_W = $clog2(ALARM_DLY_TICKS + 1);

	logic [2:0] state;
	logic strobe;
	logic reply;
	logic ok;
	logic timeout;
	logic fault;
	logic rd_cycle;
	logic [CNT_W-1:0] alarm_cnt;

	assign strobe = dr | dw;
	assign reply = rok | ren | rpe;
	assign ok = strobe & rok & ~ren & ~rpe;
	assign timeout = strobe & ~reply & (alarm_cnt == CNT_W'(ALARM_DLY_TICKS - 1));
	assign fault = (strobe & (ren | rpe)) | timeout;
	// Instruction fetch is always a read
	assign rd_cycle = (state == ST_FETCH) | mem_rd;

	// --------------------
	// Enables for PA and PR
	// --------------------

	assign w_ir = (state == ST_FETCH) & ok;
	assign icp1 = w_ir;
	assign w_ac = (state == ST_DECODE);
	assign w_r = (state == ST_EXEC) | ((state == ST_MEM) & ok & mem_rd);
	assign ic_ad = (state == ST_FETCH);
	assign ar_ad = (state == ST_MEM);

	// --------------------
	// Instruction FSM
	// --------------------

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_STOP;
			dr <= 1'b0;
			dw <= 1'b0;
			run <= 1'b0;
			hlt_n <= 1'b1;
		end else begin
			case (state)
			ST_STOP, ST_HALT: begin
				// A bus fault blocks restart until reset
				if (start && !awaria) begin
					state <= ST_FETCH;
					run <= 1'b1;
					hlt_n <= 1'b1;
				end
			end
			ST_FETCH, ST_MEM: begin
				if (fault) begin
					dr <= 1'b0;
					dw <= 1'b0;
					run <= 1'b0;
					state <= ST_STOP;
				end else if (ok) begin
					dr <= 1'b0;
					dw <= 1'b0;
					if (state == ST_FETCH) begin
						state <= ST_DECODE;
					end else if (stop) begin
						state <= ST_STOP;
						run <= 1'b0;
					end else begin
						state <= ST_FETCH;
					end
				end else if (!strobe && !reply) begin
					// New strobe only once the last reply is gone
					dr <= rd_cycle;
					dw <= ~rd_cycle;
				end
			end
			ST_DECODE: begin
				if (halt) begin
					state <= ST_HALT;
					run <= 1'b0;
					hlt_n <= 1'b0;
				end else if (reg_op) begin
					state <= ST_EXEC;
				end else if (mem_rd || mem_wr) begin
					state <= ST_MEM;
				end else begin
					// illegal opcode
					state <= ST_STOP;
					run <= ~illegal;
				end
			end
			ST_EXEC: begin
				if (stop) begin
					state <= ST_STOP;
					run <= 1'b0;
				end else begin
					state <= ST_FETCH;
				end
			end
			default: state <= ST_STOP;
			endcase
		end
	end

	// Reply timeout counter
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			alarm_cnt <= '0;
		end else if (!strobe) begin
			alarm_cnt <= '0;
		end else begin
			alarm_cnt <= alarm_cnt + 1'b1;
		end
	end

	// Sticky alarm
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			awaria <= 1'b0;
		end else if (fault) begin
			awaria <= 1'b1;
		end
	end

endmodule

// File: hw/pd.sv
// --------------------
// PD instruction decoder
// Holds IR and decodes operation and register selects
// --------------------

`timescale 1ns/1ps

module pd (
	input  logic __clk,
	input  logic arst_n,
	input  logic [0:15] rdt,
	input  logic w_ir,
	output cpu_pkg::cpu_op_t ir_op,
	output cpu_pkg::cpu_reg_t ra,
	output cpu_pkg::cpu_reg_t rb,
	output logic [0:15] t,
	output logic use_t,
	output logic reg_op,
	output logic mem_rd,
	output logic mem_wr,
	output logic halt,
	output logic illegal
);

	import cpu_pkg::*;

	cpu_instr_t ir;

	// Instruction register
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ir <= '0;
		end else if (w_ir) begin
			ir <= cpu_instr_t'(rdt);
		end
	end

	assign ir_op = cpu_op_t'(ir.rg.op);

	// --------------------
	// Instruction class
	// --------------------

	always_comb begin
		use_t = 1'b0;
		reg_op = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		halt = 1'b0;
		illegal = 1'b0;
		case (ir_op)
		OP_LWT, OP_AWT: begin
			use_t = 1'b1;
			reg_op = 1'b1;
		end
		OP_AW, OP_SW, OP_OR, OP_NR, OP_ER: reg_op = 1'b1;
		OP_LW: mem_rd = 1'b1;
		OP_RW: mem_wr = 1'b1;
		OP_HLT: halt = 1'b1;
		default: illegal = 1'b1;
		endcase
	end

	// Target register sits in the same bits in both views
	assign ra = ir.rg.a;
	assign rb = ir.rg.b;

	// Short argument sign extended to a full word
	assign t = {{10{ir.sh.t[0]}}, ir.sh.t};

endmodule

// File: hw/pa.sv
// --------------------
// PA arithmetic unit
// ALU with flag logic plus IC and AR address drivers
// --------------------

`timescale 1ns/1ps

module pa (
	input  logic __clk,
	input  logic arst_n,
	input  cpu_pkg::cpu_op_t ir_op,
	input  logic [0:15] a_val,
	input  logic [0:15] b_val,
	input  logic [0:15] t,
	input  logic use_t,
	input  logic [0:3] flags_in,
	input  logic icp1,
	input  logic w_ac,
	input  logic ic_ad,
	input  logic ar_ad,
	output logic [0:15] result,
	output logic [0:3] flags_out,
	output logic [0:15] pa_dad
);

	import cpu_pkg::*;

	logic [0:15] opb;
	logic [16:0] sum;
	logic [0:15] alu;
	logic [0:3] nf;
	logic zm;
	logic [0:15] ic;
	logic [0:15] ar;

	assign opb = use_t ? t : b_val;

	// --------------------
	// ALU and flags
	// --------------------

	always_comb begin
		sum = '0;
		alu = '0;
		nf = flags_in;
		zm = 1'b0;
		case (ir_op)
		OP_LWT: alu = t;
		OP_AW, OP_AWT: begin
			sum = {1'b0, a_val} + {1'b0, opb};
			alu = sum[15:0];
			zm = 1'b1;
			nf[FLAG_V] = (a_val[0] == opb[0]) && (alu[0] != a_val[0]);
			nf[FLAG_C] = sum[16];
		end
		OP_SW: begin
			// a + ~b + 1
			sum = {1'b0, a_val} + {1'b0, ~opb} + 17'd1;
			alu = sum[15:0];
			zm = 1'b1;
			nf[FLAG_V] = (a_val[0] != opb[0]) && (alu[0] != a_val[0]);
			nf[FLAG_C] = sum[16];
		end
		OP_OR: begin
			alu = a_val | opb;
			zm = 1'b1;
		end
		OP_NR: begin
			alu = a_val & opb;
			zm = 1'b1;
		end
		OP_ER: begin
			alu = a_val ^ opb;
			zm = 1'b1;
		end
		default: nf = flags_in;
		endcase
		if (zm) begin
			nf[FLAG_Z] = (alu == 16'h0000);
			nf[FLAG_M] = alu[0];
		end
	end

	// AC, new flags and AR latched in the decode cycle
	always_ff @(posedge __clk) begin
		if (w_ac) begin
			result <= alu;
			flags_out <= nf;
			ar <= b_val;
		end
	end

	// Instruction counter
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ic <= '0;
		end else if (icp1) begin
			ic <= ic + 16'd1;
		end
	end

	// Zero unless a source is selected
	assign pa_dad = ({16{ic_ad}} & ic) | ({16{ar_ad}} & ar);

endmodule

// File: hw/pr.sv
// --------------------
// PR register block
// R0..R7 with R0 as flags and the panel display
// --------------------

`timescale 1ns/1ps

module pr (
	input  logic __clk,
	input  logic arst_n,
	input  logic w_r,
	input  cpu_pkg::cpu_reg_t ra,
	input  cpu_pkg::cpu_reg_t rb,
	input  cpu_pkg::cpu_reg_t rsel,
	input  logic [0:15] result,
	input  logic [0:3] flags_out,
	input  logic flag_wr,
	input  logic [0:15] rdt,
	input  cpu_pkg::cpu_op_t ir_op,
	output logic [0:15] a_val,
	output logic [0:15] b_val,
	output logic [0:15] w,
	output logic [0:15] pr_ddt,
	output logic [0:3] flags
);

	import cpu_pkg::*;

	logic [0:15] r [0:7];
	logic [0:15] wdata;

	// LW takes the word from the bus
	assign wdata = (ir_op == OP_LW) ? rdt : result;

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				r[i] <= '0;
			end
		end else begin
			if (w_r) begin
				r[ra] <= wdata;
			end
			// Target R0 overwrites the whole flag word instead
			if (flag_wr && ra != 3'd0) begin
				r[0][FLAG_Z:FLAG_C] <= flags_out;
			end
		end
	end

	assign a_val = r[ra];
	assign b_val = r[rb];
	assign flags = r[0][FLAG_Z:FLAG_C];

	// Panel display
	assign w = r[rsel];

	// Data bus driver for RW
	assign pr_ddt = (ir_op == OP_RW) ? a_val : 16'h0000;

endmodule

// File: hw/cpu.sv
// --------------------
// CPU top level
// Connects PX PD PA PR and composes the bus outputs
// --------------------

`timescale 1ns/1ps

module cpu #(
	parameter int ALARM_DLY_TICKS = 64
) (
	input  logic __clk,
	input  logic arst_n,
	input  logic start,
	input  logic stop,
	input  cpu_pkg::cpu_reg_t rsel,
	input  logic rok,
	input  logic ren,
	input  logic rpe,
	input  logic [0:15] rdt,
	output logic dr,
	output logic dw,
	output logic [0:15] dad,
	output logic [0:15] ddt,
	output logic [0:15] w,
	output logic run,
	output logic hlt_n,
	output logic awaria
);

	import cpu_pkg::*;

	// Decoder outputs
	cpu_op_t ir_op;
	cpu_reg_t ra;
	cpu_reg_t rb;
	logic [0:15] t;
	logic use_t, reg_op, mem_rd, mem_wr, halt, illegal;

	// Sequencer enables
	logic w_ir, w_r, w_ac, icp1, ic_ad, ar_ad;

	// Data paths
	logic [0:15] a_val, b_val, result;
	logic [0:15] pa_dad, pr_ddt;
	logic [0:3] flags, flags_out;

	// --------------------
	// Open-collector bus composition
	// --------------------

	// PA is the only address driver and PR the only data driver
	assign dad = pa_dad;
	assign ddt = pr_ddt;

	px #(
		.ALARM_DLY_TICKS(ALARM_DLY_TICKS)
	) PX (
		.__clk(__clk),
		.arst_n(arst_n),
		.start(start),
		.stop(stop),
		.reg_op(reg_op),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.halt(halt),
		.illegal(illegal),
		.rok(rok),
		.ren(ren),
		.rpe(rpe),
		.dr(dr),
		.dw(dw),
		.run(run),
		.hlt_n(hlt_n),
		.awaria(awaria),
		.w_ir(w_ir),
		.w_r(w_r),
		.w_ac(w_ac),
		.icp1(icp1),
		.ic_ad(ic_ad),
		.ar_ad(ar_ad)
	);

	pd PD (
		.__clk(__clk),
		.arst_n(arst_n),
		.rdt(rdt),
		.w_ir(w_ir),
		.ir_op(ir_op),
		.ra(ra),
		.rb(rb),
		.t(t),
		.use_t(use_t),
		.reg_op(reg_op),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.halt(halt),
		.illegal(illegal)
	);

	pa PA (
		.__clk(__clk),
		.arst_n(arst_n),
		.ir_op(ir_op),
		.a_val(a_val),
		.b_val(b_val),
		.t(t),
		.use_t(use_t),
		.flags_in(flags),
		.icp1(icp1),
		.w_ac(w_ac),
		.ic_ad(ic_ad),
		.ar_ad(ar_ad),
		.result(result),
		.flags_out(flags_out),
		.pa_dad(pa_dad)
	);

	// Flags follow every register write
	pr PR (
		.__clk(__clk),
		.arst_n(arst_n),
		.w_r(w_r),
		.ra(ra),
		.rb(rb),
		.rsel(rsel),
		.result(result),
		.flags_out(flags_out),
		.flag_wr(w_r),
		.rdt(rdt),
		.ir_op(ir_op),
		.a_val(a_val),
		.b_val(b_val),
		.w(w),
		.pr_ddt(pr_ddt),
		.flags(flags)
	);

endmodule

// File: tb/cpu_mem.sv
// --------------------
// Behavioral system-bus memory
// Replies after random wait states, with ren or silence on request
// --------------------

`timescale 1ns/1ps

module cpu_mem (
	input  logic __clk,
	input  logic arst_n,
	input  logic dr,
	input  logic dw,
	input  logic [0:15] dad,
	input  logic [0:15] ddt,
	output logic rok,
	output logic ren,
	output logic rpe,
	output logic [0:15] rdt
);

	logic [0:15] mem [0:1023];
	// 0 normal, 1 answer ren, 2 stay silent
	logic [1:0] fault_mode;
	logic [0:9] fault_addr;
	logic busy;
	int wait_cnt;

	assign rpe = 1'b0;

	initial begin
		fault_mode = 2'd0;
		fault_addr = '0;
	end

	task automatic set_fault(input logic [1:0] mode, input logic [0:9] addr);
		fault_mode = mode;
		fault_addr = addr;
	endtask

	always @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			rok <= 1'b0;
			ren <= 1'b0;
			rdt <= '0;
			busy <= 1'b0;
			wait_cnt <= 0;
		end else if (!(dr || dw)) begin
			// Reply held until the strobe falls
			rok <= 1'b0;
			ren <= 1'b0;
			busy <= 1'b0;
		end else if (!busy && !rok && !ren) begin
			busy <= 1'b1;
			wait_cnt <= $urandom % 6;
		end else if (busy) begin
			if (wait_cnt != 0) begin
				wait_cnt <= wait_cnt - 1;
			end else if (fault_mode == 2'd1 && dad[6:15] == fault_addr) begin
				busy <= 1'b0;
				ren <= 1'b1;
			end else if (fault_mode != 2'd2 || dad[6:15] != fault_addr) begin
				busy <= 1'b0;
				rok <= 1'b1;
				if (dw) begin
					mem[dad[6:15]] <= ddt;
				end else begin
					rdt <= mem[dad[6:15]];
				end
			end
		end
	end

endmodule

// File: tb/cpu_properties.sv
// --------------------
// Bus handshake assertions
// Strobe exclusion, stable address, strobe release, sticky alarm
// --------------------

`timescale 1ns/1ps

module cpu_properties (
	input logic __clk,
	input logic arst_n,
	input logic dr,
	input logic dw,
	input logic [0:15] dad,
	input logic rok,
	input logic ren,
	input logic rpe,
	input logic awaria
);

	a_one_strobe: assert property (@(posedge __clk) disable iff (!arst_n)
		!(dr && dw))
		else $error("dr and dw high together");

	a_dad_stable: assert property (@(posedge __clk) disable iff (!arst_n)
		((dr || dw) && $past(dr || dw)) |-> $stable(dad))
		else $error("dad changed during a strobe");

	a_strobe_release: assert property (@(posedge __clk) disable iff (!arst_n)
		((dr || dw) && (rok || ren || rpe)) |=> !(dr || dw))
		else $error("strobe still high after a reply");

	a_alarm_sticky: assert property (@(posedge __clk) disable iff (!arst_n)
		awaria |=> awaria)
		else $error("awaria dropped without reset");

endmodule

// File: tb/cpu_tb.sv
// --------------------
// CPU testbench
// Directed tests against a reference model of the instruction set
// --------------------

`timescale 1ns/1ps

module cpu_tb;

	import cpu_pkg::*;

	logic clk;
	logic arst_n;
	logic start;
	logic stop;
	cpu_reg_t rsel;
	logic rok, ren, rpe;
	logic [0:15] rdt;
	logic dr, dw, run, hlt_n, awaria;
	logic [0:15] dad, ddt, w;

	int errors;
	int pc_w;
	int fetch_cnt;

	// Reference model state
	logic [0:15] m_r [0:7];
	logic [0:15] m_mem [0:1023];

	cpu #(
		.ALARM_DLY_TICKS(64)
	) UUT (
		.__clk(clk), .arst_n(arst_n), .start(start), .stop(stop), .rsel(rsel),
		.rok(rok), .ren(ren), .rpe(rpe), .rdt(rdt), .dr(dr), .dw(dw),
		.dad(dad), .ddt(ddt), .w(w), .run(run), .hlt_n(hlt_n), .awaria(awaria)
	);

	cpu_mem MEM (
		.__clk(clk), .arst_n(arst_n), .dr(dr), .dw(dw), .dad(dad), .ddt(ddt),
		.rok(rok), .ren(ren), .rpe(rpe), .rdt(rdt)
	);

	bind cpu cpu_properties PROPS (
		.__clk(__clk), .arst_n(arst_n), .dr(dr), .dw(dw), .dad(dad),
		.rok(rok), .ren(ren), .rpe(rpe), .awaria(awaria)
	);

	always #2 clk = ~clk;

	// Completed bus reads, which are all fetches in a register-only program
	always @(negedge clk) begin
		if (dr && rok) begin
			fetch_cnt++;
		end
	end

	// --------------------
	// Compare tasks and run control
	// --------------------

	task automatic compare_word(input string name, input logic [0:15] got, input logic [0:15] exp);
		if (got !== exp) begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_flags(input string name, input logic [0:3] got, input logic [0:3] exp);
		if (got !== exp) begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Simulation finished with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < 8; i++) begin
			m_r[i] = '0;
		end
	endtask

	// Fill with HLT words carrying the address in the low bits
	task automatic clear_mem();
		logic [0:15] fill;
		for (int i = 0; i < 1024; i++) begin
			fill = {6'o51, 10'(i)};
			MEM.mem[i] = fill;
			m_mem[i] = fill;
		end
		MEM.set_fault(2'd0, '0);
		pc_w = 0;
	endtask

	task automatic load_word(input int addr, input logic [0:15] val);
		MEM.mem[addr] = val;
		m_mem[addr] = val;
	endtask

	task automatic emit(input logic [0:15] word);
		load_word(pc_w, word);
		pc_w++;
	endtask

	task automatic start_program();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_run_low(input int limit);
		int n;
		n = 0;
		while (run && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (run) begin
			errors++;
			$display("Timeout: run never fell after %0d cycles", limit);
		end
	endtask

	task automatic check_regs(input string tag);
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			rsel = cpu_reg_t'(i);
			#1;
			compare_word($sformatf("%s w[R%0d]", tag, i), w, m_r[i]);
		end
	endtask

	// --------------------
	// Instruction encoding and reference model
	// --------------------

	function automatic logic [0:15] enc_reg(cpu_op_t op, cpu_reg_t a, cpu_reg_t b);
		cpu_instr_t i;
		i = '0;
		i.rg.op = op;
		i.rg.a = a;
		i.rg.b = b;
		return i;
	endfunction

	function automatic logic [0:15] enc_short(cpu_op_t op, cpu_reg_t a, logic [0:5] t6);
		cpu_instr_t i;
		i = '0;
		i.sh.op = op;
		i.sh.a = a;
		i.sh.t = t6;
		return i;
	endfunction

	// Returns 1 when the processor stops after this word
	function automatic bit model_exec(input logic [0:15] word);
		logic [0:5] op;
		logic [0:2] a, b;
		logic [0:15] ts, av, bv, opb, res;
		logic [0:15] nb;
		int us;
		int ss;
		logic [0:3] fl;
		bit wr, upd;
		op = word[0:5];
		a = word[7:9];
		b = word[10:12];
		ts = {{10{word[10]}}, word[10:15]};
		av = m_r[a];
		bv = m_r[b];
		fl = m_r[0][0:3];
		wr = 1'b1;
		upd = 1'b0;
		res = '0;
		opb = (op == 6'o41) ? ts : bv;
		case (op)
		6'o40: res = ts;
		6'o20, 6'o41: begin
			// Unsigned sum past 16 bits is a carry, signed sum out of range an overflow
			us = av + opb;
			ss = $signed(av) + $signed(opb);
			res = us[15:0];
			fl[FLAG_V] = (ss > 32767) || (ss < -32768);
			fl[FLAG_C] = (us > 65535);
			upd = 1'b1;
		end
		6'o21: begin
			nb = ~opb;
			us = av + nb + 1;
			ss = $signed(av) - $signed(opb);
			res = us[15:0];
			fl[FLAG_V] = (ss > 32767) || (ss < -32768);
			fl[FLAG_C] = (us > 65535);
			upd = 1'b1;
		end
		6'o22: begin
			res = av | bv;
			upd = 1'b1;
		end
		6'o23: begin
			res = av & bv;
			upd = 1'b1;
		end
		6'o24: begin
			res = av ^ bv;
			upd = 1'b1;
		end
		6'o10: res = m_mem[bv[6:15]];
		6'o11: begin
			m_mem[bv[6:15]] = av;
			wr = 1'b0;
		end
		default: return 1'b1;
		endcase
		if (upd) begin
			fl[FLAG_Z] = (res == 16'h0000);
			fl[FLAG_M] = res[0];
		end
		if (wr) begin
			m_r[a] = res;
			if (a != 3'd0) begin
				m_r[0][0:3] = fl;
			end
		end
		return 1'b0;
	endfunction

	task automatic run_model();
		int pc;
		pc = 0;
		while (pc < 1024 && !model_exec(m_mem[pc])) begin
			pc++;
		end
	endtask

	// --------------------
	// Directed tests
	// --------------------

	task automatic test_reset();
		apply_reset();
		compare_bit("run", run, 1'b0);
		compare_bit("dr", dr, 1'b0);
		compare_bit("dw", dw, 1'b0);
		compare_bit("awaria", awaria, 1'b0);
		compare_bit("hlt_n", hlt_n, 1'b1);
		check_regs("reset");
	endtask

	task automatic test_reg_ops();
		apply_reset();
		clear_mem();
		emit(enc_short(OP_LWT, 3'd1, 6'd13));
		emit(enc_short(OP_LWT, 3'd2, -6'd7));
		emit(enc_short(OP_AWT, 3'd1, 6'd20));
		emit(enc_reg(OP_AW, 3'd1, 3'd2));
		emit(enc_reg(OP_SW, 3'd2, 3'd1));
		emit(enc_short(OP_LWT, 3'd4, 6'h2a));
		emit(enc_reg(OP_OR, 3'd4, 3'd1));
		emit(enc_short(OP_LWT, 3'd5, -6'd1));
		emit(enc_reg(OP_NR, 3'd5, 3'd2));
		emit(enc_short(OP_LWT, 3'd3, 6'd9));
		emit(enc_reg(OP_ER, 3'd3, 3'd4));
		emit(enc_reg(OP_OR, 3'd0, 3'd3));
		emit(enc_short(OP_AWT, 3'd6, -6'd32));
		emit(enc_reg(OP_HLT, 3'd0, 3'd0));
		run_model();
		start_program();
		wait_run_low(2000);
		compare_bit("hlt_n", hlt_n, 1'b0);
		check_regs("regops");
	endtask

	task automatic test_flags();
		logic [0:15] x [0:7];
		apply_reset();
		clear_mem();
		x[0] = 16'h4000 | 16'($urandom & 32'h3fff);
		x[1] = 16'h4000 | 16'($urandom & 32'h3fff);
		x[2] = 16'($urandom) | 16'h0001;
		x[3] = -x[2];
		x[4] = 16'($urandom);
		x[5] = x[4];
		x[6] = 16'h8000 | 16'($urandom & 32'hff);
		x[7] = 16'h7f00 | 16'($urandom & 32'hff);
		for (int i = 0; i < 8; i++) begin
			load_word(10'h3e0 + i, x[i]);
		end
		emit(enc_short(OP_LWT, 3'd7, -6'd32));
		emit(enc_short(OP_LWT, 3'd6, -6'd16));
		for (int k = 0; k < 4; k++) begin
			emit(enc_reg(OP_LW, 3'd1, 3'd7));
			emit(enc_short(OP_AWT, 3'd7, 6'd1));
			emit(enc_reg(OP_LW, 3'd2, 3'd7));
			emit(enc_short(OP_AWT, 3'd7, 6'd1));
			emit(enc_reg((k < 2) ? OP_AW : OP_SW, 3'd1, 3'd2));
			emit(enc_reg(OP_RW, 3'd0, 3'd6));
			emit(enc_short(OP_AWT, 3'd6, 6'd1));
		end
		emit(enc_reg(OP_HLT, 3'd0, 3'd0));
		run_model();
		start_program();
		wait_run_low(4000);
		for (int k = 0; k < 4; k++) begin
			compare_flags($sformatf("flags of op %0d", k), MEM.mem[10'h3f0 + k][0:3],
				m_mem[10'h3f0 + k][0:3]);
			compare_word($sformatf("stored R0 %0d", k), MEM.mem[10'h3f0 + k],
				m_mem[10'h3f0 + k]);
		end
		check_regs("flags");
	endtask

	task automatic test_memory();
		apply_reset();
		clear_mem();
		for (int i = 0; i < 3; i++) begin
			load_word(10'h3e0 + i, 16'($urandom));
		end
		emit(enc_short(OP_LWT, 3'd7, -6'd32));
		emit(enc_short(OP_LWT, 3'd6, -6'd16));
		for (int i = 1; i <= 3; i++) begin
			emit(enc_reg(OP_LW, cpu_reg_t'(i), 3'd7));
			emit(enc_short(OP_AWT, 3'd7, 6'd1));
		end
		for (int i = 1; i <= 3; i++) begin
			emit(enc_reg(OP_RW, cpu_reg_t'(i), 3'd6));
			emit(enc_short(OP_AWT, 3'd6, 6'd1));
		end
		emit(enc_reg(OP_HLT, 3'd0, 3'd0));
		run_model();
		start_program();
		wait_run_low(4000);
		for (int i = 0; i < 3; i++) begin
			compare_word($sformatf("mem[%0h]", 10'h3f0 + i), MEM.mem[10'h3f0 + i],
				m_mem[10'h3f0 + i]);
		end
		compare_bit("hlt_n", hlt_n, 1'b0);
		check_regs("memory");
	endtask

	task automatic test_faults();
		logic [0:15] word0;
		// ren on the very first fetch
		apply_reset();
		clear_mem();
		emit(enc_short(OP_LWT, 3'd1, 6'd5));
		emit(enc_reg(OP_HLT, 3'd0, 3'd0));
		MEM.set_fault(2'd1, 10'd0);
		start_program();
		wait_run_low(2000);
		compare_bit("awaria after ren", awaria, 1'b1);
		compare_bit("run after ren", run, 1'b0);
		check_regs("ren");
		// Silent memory on the second fetch
		apply_reset();
		clear_mem();
		word0 = enc_short(OP_LWT, 3'd3, 6'd7);
		emit(word0);
		emit(enc_short(OP_LWT, 3'd4, 6'd9));
		MEM.set_fault(2'd2, 10'd1);
		void'(model_exec(word0));
		start_program();
		wait_run_low(2000);
		compare_bit("awaria after timeout", awaria, 1'b1);
		compare_bit("run after timeout", run, 1'b0);
		compare_bit("dr after timeout", dr, 1'b0);
		check_regs("timeout");
	endtask

	task automatic test_illegal_stop();
		apply_reset();
		clear_mem();
		emit(enc_short(OP_LWT, 3'd2, 6'd5));
		emit({6'o77, 10'd0});
		emit(enc_short(OP_LWT, 3'd3, 6'd1));
		emit(enc_reg(OP_HLT, 3'd0, 3'd0));
		run_model();
		start_program();
		wait_run_low(2000);
		compare_bit("run after illegal", run, 1'b0);
		compare_bit("awaria after illegal", awaria, 1'b0);
		compare_bit("hlt_n after illegal", hlt_n, 1'b1);
		check_regs("illegal");
		// Long program stopped part way
		apply_reset();
		clear_mem();
		emit(enc_short(OP_LWT, 3'd1, 6'd0));
		for (int i = 0; i < 60; i++) begin
			emit(enc_short(OP_AWT, 3'd1, 6'd1));
		end
		emit(enc_reg(OP_HLT, 3'd0, 3'd0));
		fetch_cnt = 0;
		start_program();
		repeat (80) @(negedge clk);
		stop = 1'b1;
		wait_run_low(200);
		stop = 1'b0;
		compare_bit("hlt_n after stop", hlt_n, 1'b1);
		if (fetch_cnt < 2 || fetch_cnt > 60) begin
			errors++;
			$display("Stop did not end the program part way after %0d fetches", fetch_cnt);
		end
		// Every fetched instruction must have completed
		for (int i = 0; i < fetch_cnt; i++) begin
			void'(model_exec(m_mem[i]));
		end
		check_regs("stop");
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		rsel = '0;
		errors = 0;
		pc_w = 0;
		fetch_cnt = 0;
		void'($urandom(32'he074));
		test_reset();
		test_reg_ops();
		test_flags();
		test_memory();
		test_faults();
		test_illegal_stop();
		finish_run();
	end

endmodule

// File: cpu.f
hw/cpu_pkg.sv
hw/px.sv
hw/pd.sv
hw/pa.sv
hw/pr.sv
hw/cpu.sv
tb/cpu_mem.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_tb -Mdir obj_dir -o cpu_sim -f cpu.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/cpu_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^NO ERRORS$"; then
	exit 0
fi
exit 1
